/* rtl/sed_settings.svh */
// ----------------------------------------
// Build-time settings of the parity link
// Data width, queue depth, counter width
// and decoder register stages
// ----------------------------------------
`ifndef SED_SETTINGS_SVH
`define SED_SETTINGS_SVH

// Message width, codeword adds one parity bit on top
`define SED_DATA_WIDTH 16

// Result queue entries, also the number of intake credits
`define SED_OUT_DEPTH 4

// Saturating error counter width
`define SED_ERR_CNT_WIDTH 8

// Decoder pipeline stages, 1 enables the register
`define SED_REG_IN 1
`define SED_REG_OUT 1

`endif

/* rtl/sed_code_pkg.sv */
// ----------------------------------------
// Codeword type of the parity link
// Even-parity helper function
// ----------------------------------------
`include "sed_settings.svh"

package sed_code_pkg;

  // ----------------------------------------
  // Codeword views
  // ----------------------------------------

  // Parity sits on the MSB, data below it
  typedef struct packed {
    logic                       parity;
    logic [`SED_DATA_WIDTH-1:0] data;
  } sed_fields_t;

  // Same word, either as a flat vector or split into fields
  typedef union packed {
    // Flat view for the xor reduction
    logic [`SED_DATA_WIDTH:0] raw;
    // Parity over data
    sed_fields_t              fields;
  } sed_codeword_u;

  // ----------------------------------------
  // Helpers
  // ----------------------------------------

  // Even parity of a data word
  // A valid codeword is {sed_parity(data), data}
  function automatic logic sed_parity(input logic [`SED_DATA_WIDTH-1:0] data);
    return ^data;
  endfunction

endpackage

/* rtl/sed_req_ack_intake.sv */
// ----------------------------------------
// Four-phase receiver of the link input
// Captures a codeword and pulses accept
// ----------------------------------------
module sed_req_ack_intake
  import sed_code_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n,
  // Sender side
  input  logic          in_req,
  input  sed_codeword_u in_codeword,
  output logic          in_ack,
  // Result port side
  input  logic          credit,
  output logic          accept,
  output sed_codeword_u rcv_codeword
);

  // Handshake states
  localparam logic StIdle  = 1'b0;
  localparam logic StAcked = 1'b1;

  logic state;
  logic capture;

  // New request, free slot, and no ack still pending
  assign capture = (state == StIdle) && in_req && credit;

  // Ack is just the acked state
  assign in_ack = (state == StAcked);

  // ----------------------------------------
  // Handshake FSM
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state  <= StIdle;
      accept <= 1'b0;
    end else begin
      // One-cycle pulse by default
      accept <= 1'b0;
      case (state)
        StIdle: begin
          if (capture) begin
            state  <= StAcked;
            accept <= 1'b1;
          end
        end
        StAcked: begin
          // Hold ack until the request drops
          if (!in_req) begin
            state <= StIdle;
          end
        end
        default: state <= StIdle;
      endcase
    end
  end

  // Payload register, loaded on capture only
  always_ff @(posedge clk) begin
    if (capture) begin
      rcv_codeword <= in_codeword;
    end
  end

  // Credit still high while the accept pulse is out
  a_accept_has_credit: assert property (
    @(posedge clk) disable iff (!rst_n) accept |-> credit
  ) else $error("accept raised while credit is low");

endmodule

/* rtl/sed_delay_valid.sv */
// ----------------------------------------
// Valid/data delay line, zero or one stage
// ----------------------------------------
module sed_delay_valid #(
  parameter int Width     = 1,
  // 0 passes through, 1 adds a register
  parameter int NumStages = 0
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             in_valid,
  input  logic [Width-1:0] in_bits,
  output logic             out_valid,
  output logic [Width-1:0] out_bits
);

  if (NumStages == 0) begin : g_pass
    // Combinational path
    assign out_valid = in_valid;
    assign out_bits  = in_bits;
  end else if (NumStages == 1) begin : g_reg
    logic             valid_q;
    logic [Width-1:0] bits_q;

    // Only valid is cleared by reset
    always_ff @(posedge clk) begin
      if (!rst_n) begin
        valid_q <= 1'b0;
      end else begin
        valid_q <= in_valid;
      end
    end

    // Data held while idle, saves toggling
    always_ff @(posedge clk) begin
      if (in_valid) begin
        bits_q <= in_bits;
      end
    end

    assign out_valid = valid_q;
    assign out_bits  = bits_q;
  end else begin : g_bad_stages
    $error("sed_delay_valid supports NumStages of 0 or 1 only");
  end

endmodule

/* rtl/sed_decoder.sv */
// ----------------------------------------
// Single-error-detecting parity decoder
// Optional input and output registers
// ----------------------------------------
module sed_decoder
  import sed_code_pkg::*;
#(
  // Register stage ahead of the parity check
  parameter bit RegisterInputs  = 0,
  // Register stage behind the parity check
  parameter bit RegisterOutputs = 0
) (
  input  logic          clk,
  input  logic          rst_n,
  // Received codeword, may carry errors
  input  logic          rcv_valid,
  input  sed_codeword_u rcv_codeword,
  // Checked codeword and error flag
  output logic          dec_valid,
  output sed_codeword_u dec_codeword,
  output logic          dec_error
);

  localparam int CodewordWidth = $bits(sed_codeword_u);
  localparam int Latency       = int'(RegisterInputs) + int'(RegisterOutputs);

  // ----------------------------------------
  // Input stage
  // ----------------------------------------
  logic          rcv_valid_d;
  sed_codeword_u rcv_codeword_d;

  sed_delay_valid #(
    .Width    (CodewordWidth),
    .NumStages(RegisterInputs ? 1 : 0)
  ) u_delay_in (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (rcv_valid),
    .in_bits  (rcv_codeword),
    .out_valid(rcv_valid_d),
    .out_bits (rcv_codeword_d)
  );

  // ----------------------------------------
  // Parity check
  // ----------------------------------------
  // Odd weight over data plus parity means a detected error
  // No correction possible with a single parity bit
  logic syndrome;

  assign syndrome = ^rcv_codeword_d.raw;

  // ----------------------------------------
  // Output stage
  // ----------------------------------------
  // Codeword forwarded untouched, flag in the LSB
  logic [CodewordWidth:0] stage_out;

  sed_delay_valid #(
    .Width    (CodewordWidth + 1),
    .NumStages(RegisterOutputs ? 1 : 0)
  ) u_delay_out (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (rcv_valid_d),
    .in_bits  ({rcv_codeword_d.raw, syndrome}),
    .out_valid(dec_valid),
    .out_bits (stage_out)
  );

  assign dec_codeword = stage_out[CodewordWidth:1];
  assign dec_error    = stage_out[0];

  // Every input shows up after exactly the configured stages
  a_latency: assert property (
    @(posedge clk) disable iff (!rst_n) rcv_valid |-> ##Latency dec_valid
  ) else $error("dec_valid missing %0d cycles after rcv_valid", Latency);

endmodule

/* rtl/sed_result_port.sv */
// ----------------------------------------
// Result queue with credit count
// Four-phase sender of data and error flag
// Saturating detected-error counter
// ----------------------------------------
`include "sed_settings.svh"

module sed_result_port
  import sed_code_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst_n,
  // Slot reservation from the intake
  input  logic                         accept,
  output logic                         credit,
  // Decoder results
  input  logic                         dec_valid,
  input  sed_codeword_u                dec_codeword,
  input  logic                         dec_error,
  // Consumer handshake
  output logic                         out_req,
  output logic [`SED_DATA_WIDTH-1:0]   out_data,
  output logic                         out_error,
  input  logic                         out_ack,
  // Detected errors so far
  output logic [`SED_ERR_CNT_WIDTH-1:0] err_count
);

  localparam int Depth    = `SED_OUT_DEPTH;
  localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntWidth = $clog2(Depth + 1);

  // ----------------------------------------
  // Queue storage
  // ----------------------------------------
  // Entry is {error, data}
  logic [`SED_DATA_WIDTH:0] mem [Depth];
  logic [PtrWidth-1:0]      wr_ptr;
  logic [PtrWidth-1:0]      rd_ptr;
  logic [CntWidth-1:0]      fill;
  logic [CntWidth-1:0]      reserved;
  logic                     push;
  logic                     pop;
  logic                     empty;
  logic                     full;

  assign push  = dec_valid;
  // Entry leaves once the consumer acks it
  assign pop   = out_req && out_ack;
  assign empty = (fill == '0);
  assign full  = (fill == CntWidth'(Depth));

  // Room left for another codeword in flight
  assign credit = (reserved < CntWidth'(Depth));

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= {dec_error, dec_codeword.fields.data};
    end
  end

  // Pointers, occupancy and reservations
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fill     <= '0;
      reserved <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PtrWidth'(Depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PtrWidth'(Depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Occupancy of the queue itself
      case ({push, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
      // Slot held from accept until pop
      case ({accept, pop})
        2'b10:   reserved <= reserved + 1'b1;
        2'b01:   reserved <= reserved - 1'b1;
        default: reserved <= reserved;
      endcase
    end
  end

  // ----------------------------------------
  // Output handshake
  // ----------------------------------------
  // Head entry stays put until the pop
  assign out_data  = mem[rd_ptr][`SED_DATA_WIDTH-1:0];
  assign out_error = mem[rd_ptr][`SED_DATA_WIDTH];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_req <= 1'b0;
    end else if (out_req) begin
      // Drop request on ack
      if (out_ack) begin
        out_req <= 1'b0;
      end
    end else if (!empty && !out_ack) begin
      // Previous ack must be low again first
      out_req <= 1'b1;
    end
  end

  // ----------------------------------------
  // Error counter
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      err_count <= '0;
    end else if (dec_valid && dec_error && (err_count != '1)) begin
      err_count <= err_count + 1'b1;
    end
  end

  // Credit flow keeps the decoder from overrunning the queue
  a_no_write_full: assert property (
    @(posedge clk) disable iff (!rst_n) dec_valid |-> !full
  ) else $error("decoder result written into a full queue");

  a_reserved_bound: assert property (
    @(posedge clk) disable iff (!rst_n) reserved <= CntWidth'(Depth)
  ) else $error("reserved slots %0d above depth %0d", reserved, Depth);

endmodule

/* rtl/sed_check_link.sv */
// ----------------------------------------
// Top of the parity-checked receive link
// Intake, decoder and result port
// ----------------------------------------
`include "sed_settings.svh"

module sed_check_link
  import sed_code_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst_n,
  // Codeword input handshake
  input  logic                          in_req,
  input  sed_codeword_u                 in_codeword,
  output logic                          in_ack,
  // Result output handshake
  output logic                          out_req,
  output logic [`SED_DATA_WIDTH-1:0]    out_data,
  output logic                          out_error,
  input  logic                          out_ack,
  // Saturating detected-error count
  output logic [`SED_ERR_CNT_WIDTH-1:0] err_count
);

  // Accept doubles as the decoder input valid
  logic          accept;
  logic          credit;
  sed_codeword_u rcv_codeword;
  logic          dec_valid;
  sed_codeword_u dec_codeword;
  logic          dec_error;

  sed_req_ack_intake u_intake (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_req      (in_req),
    .in_codeword (in_codeword),
    .in_ack      (in_ack),
    .credit      (credit),
    .accept      (accept),
    .rcv_codeword(rcv_codeword)
  );

  sed_decoder #(
    .RegisterInputs (`SED_REG_IN),
    .RegisterOutputs(`SED_REG_OUT)
  ) u_decoder (
    .clk         (clk),
    .rst_n       (rst_n),
    .rcv_valid   (accept),
    .rcv_codeword(rcv_codeword),
    .dec_valid   (dec_valid),
    .dec_codeword(dec_codeword),
    .dec_error   (dec_error)
  );

  sed_result_port u_result_port (
    .clk         (clk),
    .rst_n       (rst_n),
    .accept      (accept),
    .credit      (credit),
    .dec_valid   (dec_valid),
    .dec_codeword(dec_codeword),
    .dec_error   (dec_error),
    .out_req     (out_req),
    .out_data    (out_data),
    .out_error   (out_error),
    .out_ack     (out_ack),
    .err_count   (err_count)
  );

endmodule

/* verification/sed_check_link_tb.sv */
// ----------------------------------------
// Testbench of the parity-checked link
// LFSR stimulus, reference model, compare
// tasks and a result scoreboard
// ----------------------------------------
`include "sed_settings.svh"

module sed_check_link_tb
  import sed_code_pkg::*;
;

  localparam int DataW      = `SED_DATA_WIDTH;
  localparam int CntW       = `SED_ERR_CNT_WIDTH;
  localparam int CwWidth    = $bits(sed_codeword_u);
  localparam int CountMax   = (1 << CntW) - 1;
  // 640 items push the error count well past saturation
  localparam int NumItems   = 640;
  localparam int Timeout    = 200;
  localparam int StallCycles = 60;
  // in_ack rise to err_count update, intake plus decoder plus result port
  localparam int CountDelay = 1 + `SED_REG_IN + `SED_REG_OUT;

  typedef logic [DataW-1:0] data_t;
  typedef logic [CntW-1:0]  count_t;

  // Expected output of one codeword
  typedef struct packed {
    sed_codeword_u word;
    logic          error;
  } result_t;

  logic          clk;
  logic          rst_n;
  logic          in_req;
  sed_codeword_u in_codeword;
  logic          in_ack;
  logic          out_req;
  data_t         out_data;
  logic          out_error;
  logic          out_ack;
  count_t        err_count;

  logic [31:0]   lfsr_state = 32'h51f7;
  sed_codeword_u stim_cw [NumItems];
  int            stim_delay [NumItems];
  result_t       exp_q [$];
  int            sent_odd;
  int            data_errs;
  int            flag_errs;
  int            count_errs;
  int            other_errs;
  logic          abort;

  sed_check_link dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_req     (in_req),
    .in_codeword(in_codeword),
    .in_ack     (in_ack),
    .out_req    (out_req),
    .out_data   (out_data),
    .out_error  (out_error),
    .out_ack    (out_ack),
    .err_count  (err_count)
  );

  always #2 clk = ~clk;

  // ----------------------------------------
  // Random source and reference model
  // ----------------------------------------
  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per returned bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Data is forwarded as received, flag set on odd weight
  function automatic result_t expected_result(input sed_codeword_u sent);
    result_t r;
    int      ones;
    ones = 0;
    for (int i = 0; i < CwWidth; i++) begin
      if (sent.raw[i]) begin
        ones++;
      end
    end
    r.word  = sent;
    r.error = (ones % 2) == 1;
    return r;
  endfunction

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------
  task automatic check_data(input data_t got, input sed_codeword_u want);
    if (got !== want.fields.data) begin
      data_errs++;
      $display("** Error at %0t: out_data got %h, expected %h", $time, got,
               want.fields.data);
    end
  endtask

  task automatic check_error(input string name, input logic got, input logic want);
    if (got !== want) begin
      flag_errs++;
      $display("** Error at %0t: %s got %b, expected %b", $time, name, got, want);
    end
  endtask

  task automatic check_count(input count_t got, input count_t want);
    if (got !== want) begin
      count_errs++;
      $display("** Error at %0t: err_count got %0d, expected %0d", $time, got, want);
    end
  endtask

  task automatic report_failure(input string what);
    other_errs++;
    $display("Failure at %0t: %s", $time, what);
  endtask

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  // Kinds: 0 clean, 1 two flips, 2 or 3 one flip
  task automatic build_stimulus();
    logic [31:0] r;
    int          kind;
    int          pos_a;
    int          pos_b;
    for (int i = 0; i < NumItems; i++) begin
      r = take_bits(DataW);
      stim_cw[i].fields.data   = r[DataW-1:0];
      stim_cw[i].fields.parity = sed_parity(r[DataW-1:0]);
      kind  = int'(take_bits(2));
      pos_a = int'(take_bits(5)) % CwWidth;
      // Second position always differs from the first
      pos_b = (pos_a + 1 + int'(take_bits(4))) % CwWidth;
      // Opening items hit each case once
      if (i == 0) begin
        kind = 0;
      end else if (i == 1) begin
        kind  = 2;
        pos_a = DataW;
      end else if (i == 2) begin
        kind  = 2;
        pos_a = pos_a % DataW;
      end else if (i == 3) begin
        kind = 1;
      end
      if (kind != 0) begin
        stim_cw[i].raw[pos_a] = ~stim_cw[i].raw[pos_a];
      end
      if (kind == 1) begin
        stim_cw[i].raw[pos_b] = ~stim_cw[i].raw[pos_b];
      end
      stim_delay[i] = int'(take_bits(3));
    end
  endtask

  // Four-phase sender, one codeword at a time
  task automatic drive_codewords();
    int      cycles;
    result_t want;
    for (int i = 0; i < NumItems && !abort; i++) begin
      in_codeword = stim_cw[i];
      in_req      = 1'b1;
      want        = expected_result(stim_cw[i]);
      exp_q.push_back(want);
      if (want.error) begin
        sent_odd++;
      end
      cycles = 0;
      while (!in_ack && cycles < Timeout) begin
        @(posedge clk);
        #1;
        cycles++;
      end
      if (!in_ack) begin
        report_failure($sformatf("in_ack never rose for codeword %0d", i));
        abort = 1'b1;
      end else begin
        in_req = 1'b0;
        cycles = 0;
        while (in_ack && cycles < Timeout) begin
          @(posedge clk);
          #1;
          cycles++;
        end
        if (in_ack) begin
          report_failure($sformatf("in_ack stuck high after codeword %0d", i));
          abort = 1'b1;
        end
      end
    end
  endtask

  // Consumer, opens with a stall to fill the queue
  task automatic consume_results();
    int   cycles;
    int   stall_acks;
    logic ack_prev;
    stall_acks = 0;
    ack_prev   = in_ack;
    repeat (StallCycles) begin
      @(posedge clk);
      #1;
      if (in_ack && !ack_prev) begin
        stall_acks++;
      end
      ack_prev = in_ack;
    end
    if (stall_acks > `SED_OUT_DEPTH) begin
      report_failure($sformatf("in_ack rose %0d times while out_ack was held back",
                               stall_acks));
    end
    for (int i = 0; i < NumItems && !abort; i++) begin
      cycles = 0;
      while (!out_req && cycles < Timeout) begin
        @(posedge clk);
        #1;
        cycles++;
      end
      if (!out_req) begin
        report_failure($sformatf("out_req never rose for result %0d", i));
        abort = 1'b1;
      end else begin
        repeat (stim_delay[i]) begin
          @(posedge clk);
          #1;
        end
        out_ack = 1'b1;
        cycles  = 0;
        while (out_req && cycles < Timeout) begin
          @(posedge clk);
          #1;
          cycles++;
        end
        if (out_req) begin
          report_failure($sformatf("out_req stayed high after ack of result %0d", i));
          abort = 1'b1;
        end
        out_ack = 1'b0;
      end
    end
  endtask

  // Scoreboard, one expected entry per out_req rise
  // Count model follows every acked codeword to the counter
  task automatic compare_results();
    result_t               want;
    result_t               acked;
    int                    cycles;
    int                    seen;
    int                    model_count;
    logic                  req_prev;
    logic                  ack_prev;
    logic                  odd_ack;
    logic [CountDelay-1:0] odd_pipe;
    cycles      = 0;
    seen        = 0;
    model_count = 0;
    req_prev    = out_req;
    ack_prev    = in_ack;
    odd_pipe    = '0;
    while (seen < NumItems && cycles < Timeout && !abort) begin
      @(negedge clk);
      cycles++;
      // Odd codeword lands in the count a fixed time after its ack
      if (odd_pipe[CountDelay-1] && model_count < CountMax) begin
        model_count++;
      end
      acked    = expected_result(in_codeword);
      odd_ack  = in_ack && !ack_prev && acked.error;
      odd_pipe = (odd_pipe << 1) | CountDelay'(odd_ack);
      ack_prev = in_ack;
      check_count(err_count, count_t'(model_count));
      if (out_req && !req_prev) begin
        cycles = 0;
        seen++;
        if (exp_q.size() == 0) begin
          report_failure("a result came out with nothing sent for it");
        end else begin
          want = exp_q.pop_front();
          check_data(out_data, want.word);
          check_error("out_error", out_error, want.error);
        end
      end
      req_prev = out_req;
    end
    if (seen < NumItems) begin
      report_failure($sformatf("only %0d of %0d results arrived", seen, NumItems));
    end
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    in_req      = 1'b0;
    in_codeword = '0;
    out_ack     = 1'b0;
    abort       = 1'b0;
    sent_odd    = 0;
    data_errs   = 0;
    flag_errs   = 0;
    count_errs  = 0;
    other_errs  = 0;
    build_stimulus();
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // Idle state straight out of reset
    check_error("in_ack", in_ack, 1'b0);
    check_error("out_req", out_req, 1'b0);
    check_count(err_count, '0);
    fork
      drive_codewords();
      consume_results();
      compare_results();
    join
    if (exp_q.size() != 0) begin
      report_failure($sformatf("%0d expected results never came out", exp_q.size()));
    end
    check_count(err_count, count_t'((sent_odd > CountMax) ? CountMax : sent_odd));
    $display("Error counts: data %0d, flag %0d, count %0d, other %0d",
             data_errs, flag_errs, count_errs, other_errs);
    if (data_errs + flag_errs + count_errs + other_errs == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* sed_check_link.f */
+incdir+rtl
rtl/sed_code_pkg.sv
rtl/sed_req_ack_intake.sv
rtl/sed_delay_valid.sv
rtl/sed_decoder.sv
rtl/sed_result_port.sv
rtl/sed_check_link.sv
verification/sed_check_link_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the parity link testbench with Verilator
# Exit status is nonzero unless the pass message is seen

cd "$(dirname "$0")" &&
  verilator --binary --assert -f sed_check_link.f --top-module sed_check_link_tb &&
  ./obj_dir/Vsed_check_link_tb | tee /dev/stderr | grep -q "ALL CHECKS PASSED" &&
  echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }
